/* rq_pkg.sv */
// Request queue package
// Entry formats of the RHQ, RDQ and BIQ heads and the
// encoding of the pop state machine

package rq_pkg;

   // Request header entry, high word in 63:32
   localparam int RHQ_W = 64;

   // Four data words in 127:0 and four ECC fields in 155:128
   // Word 0 sits in the highest slot of both
   localparam int RDQ_W = 156;

   // BIQ entry, either a header or two data words
   localparam int BIQ_W     = 64;
   localparam int BIQ_ECC_W = 14;

   // Data word counter
   localparam int DATA_CNT_W = 4;

   // Pop state machine
   typedef enum logic [2:0] {
      IDLE,
      HDR0,
      HDR1,
      WRI_D,
      WR8_D0,
      WR8_D1,
      RD_WAIT0,
      RD_WAIT1
   } pop_state_e;

endpackage

/* sctag_pkg.sv */
// L2 tag slice request package
// Outbound word format, request opcodes and credit defaults

package sctag_pkg;

   // Request word and its ECC
   localparam int WORD_W = 32;
   localparam int ECC_W  = 7;

   // Request opcodes, one hot
   typedef enum logic [2:0] {
      REQ_RDD = 3'b001,
      REQ_WR8 = 3'b010,
      REQ_WRI = 3'b100
   } req_e;

   // Opcode field in the high header word
   // Header bits 60:58
   localparam int REQ_HI = 28;
   localparam int REQ_LO = 26;

   // Low header word address bits for the 8-byte slot
   localparam int ADDR_LINE_HI = 5;
   localparam int ADDR_LINE_LO = 3;

   // Invalidate buffer entries at the slice
   localparam int IB_CREDITS_DEF = 2;

   // Outstanding WRI counter
   localparam int WIB_CNT_W = 3;

endpackage

/* rq_issue_arbiter.sv */
`timescale 1ns/1ps

// Issue arbiter
// Qualifies the RHQ and BIQ heads against the credit stalls
// and picks the source of each transaction round robin

module rq_issue_arbiter (
   input  logic                       cpu_clk,
   input  logic                       cpu_rst_l,
   input  rq_pkg::pop_state_e         pop_state,
   input  logic                       rhq_drdy,
   input  logic [rq_pkg::RHQ_W-1:0]   rhq_rdata,
   input  logic                       biq_drdy,
   input  logic [rq_pkg::BIQ_W-1:0]   biq_rdata_data,
   input  logic                       stall_ib,
   input  logic                       stall_wib,
   output logic                       issue_txn,
   output logic                       driving_bsc,
   output sctag_pkg::req_e            winner_op
);

   // Opcode position within a full 64-bit header
   localparam int OP_HI = sctag_pkg::REQ_HI + sctag_pkg::WORD_W;
   localparam int OP_LO = sctag_pkg::REQ_LO + sctag_pkg::WORD_W;

   sctag_pkg::req_e rhq_op;
   sctag_pkg::req_e biq_op;
   logic            rhq_drdy_ok;
   logic            bsc_drdy_ok;
   logic            next_driving_bsc;
   logic            priority_bsc;
   logic            load_winner;

   assign rhq_op = sctag_pkg::req_e'(rhq_rdata[OP_HI:OP_LO]);
   assign biq_op = sctag_pkg::req_e'(biq_rdata_data[OP_HI:OP_LO]);

   // ************************************************
   // Source readiness
   // ************************************************
   // Nothing issues with IB full, WRI also waits on WIB
   assign rhq_drdy_ok = rhq_drdy & ~stall_ib
                      & ~(stall_wib & (rhq_op == sctag_pkg::REQ_WRI));
   assign bsc_drdy_ok = biq_drdy & ~stall_ib
                      & ~(stall_wib & (biq_op == sctag_pkg::REQ_WRI));

   assign issue_txn = rhq_drdy_ok | bsc_drdy_ok;

   // ************************************************
   // Round robin
   // ************************************************
   assign load_winner = (pop_state == rq_pkg::IDLE) & issue_txn;

   // BIQ wins alone or when it holds priority
   assign next_driving_bsc = bsc_drdy_ok & (priority_bsc | ~rhq_drdy_ok);

   always_ff @(posedge cpu_clk) begin
      if (!cpu_rst_l) begin
         driving_bsc  <= 1'b0;
         priority_bsc <= 1'b0;
      end else if (load_winner) begin
         driving_bsc  <= next_driving_bsc;
         // Losing source goes first next time
         priority_bsc <= ~next_driving_bsc;
      end
   end

   // Opcode of the head being issued
   assign winner_op = driving_bsc ? biq_op : rhq_op;

endmodule

/* rq_pop_fsm.sv */
`timescale 1ns/1ps

// Pop state machine
// Steps header, data and wait phases of each transaction
// and forms the RHQ, RDQ and BIQ pop strobes

module rq_pop_fsm (
   input  logic                            cpu_clk,
   input  logic                            cpu_rst_l,
   input  logic                            issue_txn,
   input  sctag_pkg::req_e                 winner_op,
   input  logic                            driving_bsc,
   input  logic [rq_pkg::DATA_CNT_W-1:0]   data_cnt,
   output rq_pkg::pop_state_e              pop_state,
   output logic                            issue_rhq_pop,
   output logic                            issue_rdq_pop,
   output logic                            issue_biq_pop
);

   rq_pkg::pop_state_e next_state;
   logic               in_hdr1;
   logic               in_wri_d;

   // ************************************************
   // Next state
   // ************************************************
   always_comb begin
      next_state = pop_state;
      case (pop_state)
         rq_pkg::IDLE: begin
            if (issue_txn) begin
               next_state = rq_pkg::HDR0;
            end
         end
         rq_pkg::HDR0: next_state = rq_pkg::HDR1;
         // Head opcode still valid here, pop lands at the edge
         rq_pkg::HDR1: begin
            case (winner_op)
               sctag_pkg::REQ_WRI: next_state = rq_pkg::WRI_D;
               sctag_pkg::REQ_WR8: next_state = rq_pkg::WR8_D0;
               default:            next_state = rq_pkg::RD_WAIT0;
            endcase
         end
         // 16 words, counter runs 0 to 15
         rq_pkg::WRI_D: begin
            if (&data_cnt) begin
               next_state = rq_pkg::IDLE;
            end
         end
         rq_pkg::WR8_D0:   next_state = rq_pkg::WR8_D1;
         rq_pkg::WR8_D1:   next_state = rq_pkg::IDLE;
         // Read has no data, two idle beats
         rq_pkg::RD_WAIT0: next_state = rq_pkg::RD_WAIT1;
         rq_pkg::RD_WAIT1: next_state = rq_pkg::IDLE;
         default:          next_state = rq_pkg::IDLE;
      endcase
   end

   always_ff @(posedge cpu_clk) begin
      if (!cpu_rst_l) begin
         pop_state <= rq_pkg::IDLE;
      end else begin
         pop_state <= next_state;
      end
   end

   // ************************************************
   // Pop strobes
   // ************************************************
   assign in_hdr1  = (pop_state == rq_pkg::HDR1);
   assign in_wri_d = (pop_state == rq_pkg::WRI_D);

   // Header leaves its queue after the low word is taken
   assign issue_rhq_pop = in_hdr1 & ~driving_bsc;

   // RDQ entry done after word 3, or after the second WR8 word
   assign issue_rdq_pop = ~driving_bsc
                        & ((in_wri_d & (&data_cnt[1:0]))
                           | (pop_state == rq_pkg::WR8_D1));

   // BIQ header, then each data entry on its low half
   assign issue_biq_pop = driving_bsc & (in_hdr1 | (in_wri_d & data_cnt[0]));

endmodule

/* rq_data_counter.sv */
`timescale 1ns/1ps

// Data word counter
// Indexes the outbound data words, starting at the header's
// 8-byte slot for RHQ transactions

module rq_data_counter (
   input  logic                            cpu_clk,
   input  logic                            cpu_rst_l,
   input  rq_pkg::pop_state_e              pop_state,
   input  logic                            driving_bsc,
   input  logic [rq_pkg::RHQ_W-1:0]        rhq_rdata,
   output logic [rq_pkg::DATA_CNT_W-1:0]   data_cnt
);

   logic in_data;

   // Any data beat
   assign in_data = (pop_state == rq_pkg::WRI_D)
                  | (pop_state == rq_pkg::WR8_D0)
                  | (pop_state == rq_pkg::WR8_D1);

   always_ff @(posedge cpu_clk) begin
      if (!cpu_rst_l) begin
         data_cnt <= '0;
      end else if (pop_state == rq_pkg::HDR1) begin
         // BIQ always starts at entry 0
         if (driving_bsc) begin
            data_cnt <= '0;
         end else begin
            data_cnt <= {rhq_rdata[sctag_pkg::ADDR_LINE_HI:sctag_pkg::ADDR_LINE_LO], 1'b0};
         end
      end else if (in_data) begin
         data_cnt <= data_cnt + 1'b1;
      end
   end

endmodule

/* sctag_credit_tracker.sv */
`timescale 1ns/1ps

// Slice credit tracker
// Counts free IB entries and outstanding WRIs from the issued
// requests and the slice dequeue strobes

module sctag_credit_tracker #(
   parameter int IB_CREDITS = sctag_pkg::IB_CREDITS_DEF
) (
   input  logic                           cpu_clk,
   input  logic                           cpu_rst_l,
   input  logic [1:0]                     max_wris,
   input  logic                           sctag_jbi_iq_dequeue,
   input  logic                           sctag_jbi_wib_dequeue,
   input  logic                           jbi_sctag_req_vld,
   input  logic [sctag_pkg::WORD_W-1:0]   jbi_sctag_req,
   output logic                           stall_ib,
   output logic                           stall_wib
);

   localparam int                  IB_CNT_W = $clog2(IB_CREDITS + 1);
   localparam logic [IB_CNT_W-1:0] IB_INIT  = IB_CNT_W'(IB_CREDITS);

   logic                            iq_dequeue_ff;
   logic                            wib_dequeue_ff;
   logic                            wri_issued;
   logic                            incr_wib_cnt;
   logic [IB_CNT_W-1:0]             ib_cnt;
   logic [sctag_pkg::WIB_CNT_W-1:0] wib_cnt;

   // High header word is on the bus while vld is up
   assign wri_issued = jbi_sctag_req_vld
                     & (jbi_sctag_req[sctag_pkg::REQ_HI:sctag_pkg::REQ_LO]
                        == sctag_pkg::REQ_WRI);

   // Event flops
   always_ff @(posedge cpu_clk) begin
      if (!cpu_rst_l) begin
         iq_dequeue_ff  <= 1'b0;
         wib_dequeue_ff <= 1'b0;
         incr_wib_cnt   <= 1'b0;
      end else begin
         iq_dequeue_ff  <= sctag_jbi_iq_dequeue;
         wib_dequeue_ff <= sctag_jbi_wib_dequeue;
         incr_wib_cnt   <= wri_issued;
      end
   end

   // ************************************************
   // IB credits, every request takes one
   // ************************************************
   always_ff @(posedge cpu_clk) begin
      if (!cpu_rst_l) begin
         ib_cnt <= IB_INIT;
      end else begin
         case ({iq_dequeue_ff, jbi_sctag_req_vld})
            2'b10:   ib_cnt <= ib_cnt + 1'b1;
            2'b01:   ib_cnt <= ib_cnt - 1'b1;
            default: ib_cnt <= ib_cnt;
         endcase
      end
   end

   assign stall_ib = (ib_cnt == '0);

   // ************************************************
   // WIB count, WRI only
   // ************************************************
   always_ff @(posedge cpu_clk) begin
      if (!cpu_rst_l) begin
         wib_cnt <= '0;
      end else begin
         case ({incr_wib_cnt, wib_dequeue_ff})
            2'b10:   wib_cnt <= wib_cnt + 1'b1;
            2'b01:   wib_cnt <= wib_cnt - 1'b1;
            default: wib_cnt <= wib_cnt;
         endcase
      end
   end

   // Over the programmed limit
   assign stall_wib = (wib_cnt > sctag_pkg::WIB_CNT_W'(max_wris));

endmodule

/* sctag_req_mux.sv */
`timescale 1ns/1ps

// Slice request mux
// Picks header or data word and ECC for the current beat
// and registers them onto the slice request bus

module sctag_req_mux (
   input  logic                              cpu_clk,
   input  logic                              cpu_rst_l,
   input  rq_pkg::pop_state_e                pop_state,
   input  logic                              driving_bsc,
   input  logic [rq_pkg::DATA_CNT_W-1:0]     data_cnt,
   input  logic [rq_pkg::RHQ_W-1:0]          rhq_rdata,
   input  logic [rq_pkg::RDQ_W-1:0]          rdq_rdata,
   input  logic [rq_pkg::BIQ_W-1:0]          biq_rdata_data,
   input  logic [rq_pkg::BIQ_ECC_W-1:0]      biq_rdata_ecc,
   output logic                              jbi_sctag_req_vld,
   output logic [sctag_pkg::WORD_W-1:0]      jbi_sctag_req,
   output logic [sctag_pkg::ECC_W-1:0]       jbi_scbuf_ecc
);

   localparam int W         = sctag_pkg::WORD_W;
   localparam int E         = sctag_pkg::ECC_W;
   localparam int DATA_BITS = 4 * W;

   logic [rq_pkg::RHQ_W-1:0] hdr;
   logic [1:0]               rdq_slot;
   logic [W-1:0]             rdq_word;
   logic [E-1:0]             rdq_ecc;
   logic [W-1:0]             biq_word;
   logic [E-1:0]             biq_ecc;
   logic [W-1:0]             next_req;
   logic [E-1:0]             next_ecc;

   // Header of the driving source
   assign hdr = driving_bsc ? biq_rdata_data : rhq_rdata;

   // RDQ word 0 is the top slot
   assign rdq_slot = ~data_cnt[1:0];
   assign rdq_word = rdq_rdata[rdq_slot * W +: W];
   assign rdq_ecc  = rdq_rdata[DATA_BITS + rdq_slot * E +: E];

   // BIQ high half first, low half on odd counts
   assign biq_word = data_cnt[0] ? biq_rdata_data[W-1:0] : biq_rdata_data[2*W-1:W];
   assign biq_ecc  = data_cnt[0] ? biq_rdata_ecc[E-1:0] : biq_rdata_ecc[2*E-1:E];

   // ************************************************
   // Beat select
   // ************************************************
   always_comb begin
      next_req = '0;
      next_ecc = '0;
      case (pop_state)
         rq_pkg::HDR0: next_req = hdr[2*W-1:W];
         rq_pkg::HDR1: next_req = hdr[W-1:0];
         rq_pkg::WRI_D, rq_pkg::WR8_D0, rq_pkg::WR8_D1: begin
            next_req = driving_bsc ? biq_word : rdq_word;
            next_ecc = driving_bsc ? biq_ecc : rdq_ecc;
         end
         default: begin
            next_req = '0;
         end
      endcase
   end

   // Payload flops
   always_ff @(posedge cpu_clk) begin
      jbi_sctag_req <= next_req;
      jbi_scbuf_ecc <= next_ecc;
   end

   // vld lines up with the high header word
   always_ff @(posedge cpu_clk) begin
      if (!cpu_rst_l) begin
         jbi_sctag_req_vld <= 1'b0;
      end else begin
         jbi_sctag_req_vld <= (pop_state == rq_pkg::HDR0);
      end
   end

endmodule

/* rq_issue_top.sv */
`timescale 1ns/1ps

// Request issue stage
// Arbitrates RHQ/RDQ and BIQ transactions and streams them
// to the L2 tag slice under IB and WIB credits

module rq_issue_top #(
   parameter int IB_CREDITS = sctag_pkg::IB_CREDITS_DEF
) (
   input  logic                             cpu_clk,
   input  logic                             cpu_rst_l,
   input  logic [1:0]                       max_wris,
   input  logic                             rhq_drdy,
   input  logic [rq_pkg::RHQ_W-1:0]         rhq_rdata,
   input  logic [rq_pkg::RDQ_W-1:0]         rdq_rdata,
   input  logic                             biq_drdy,
   input  logic [rq_pkg::BIQ_W-1:0]         biq_rdata_data,
   input  logic [rq_pkg::BIQ_ECC_W-1:0]     biq_rdata_ecc,
   input  logic                             sctag_jbi_iq_dequeue,
   input  logic                             sctag_jbi_wib_dequeue,
   output logic                             issue_rhq_pop,
   output logic                             issue_rdq_pop,
   output logic                             issue_biq_pop,
   output logic                             jbi_sctag_req_vld,
   output logic [sctag_pkg::WORD_W-1:0]     jbi_sctag_req,
   output logic [sctag_pkg::ECC_W-1:0]      jbi_scbuf_ecc
);

   logic                            issue_txn;
   logic                            driving_bsc;
   sctag_pkg::req_e                 winner_op;
   rq_pkg::pop_state_e              pop_state;
   logic [rq_pkg::DATA_CNT_W-1:0]   data_cnt;
   logic                            stall_ib;
   logic                            stall_wib;

   // Source selection
   rq_issue_arbiter u_arbiter (
      .cpu_clk        (cpu_clk),
      .cpu_rst_l      (cpu_rst_l),
      .pop_state      (pop_state),
      .rhq_drdy       (rhq_drdy),
      .rhq_rdata      (rhq_rdata),
      .biq_drdy       (biq_drdy),
      .biq_rdata_data (biq_rdata_data),
      .stall_ib       (stall_ib),
      .stall_wib      (stall_wib),
      .issue_txn      (issue_txn),
      .driving_bsc    (driving_bsc),
      .winner_op      (winner_op)
   );

   // Transaction sequencing and queue pops
   rq_pop_fsm u_pop_fsm (
      .cpu_clk       (cpu_clk),
      .cpu_rst_l     (cpu_rst_l),
      .issue_txn     (issue_txn),
      .winner_op     (winner_op),
      .driving_bsc   (driving_bsc),
      .data_cnt      (data_cnt),
      .pop_state     (pop_state),
      .issue_rhq_pop (issue_rhq_pop),
      .issue_rdq_pop (issue_rdq_pop),
      .issue_biq_pop (issue_biq_pop)
   );

   rq_data_counter u_data_counter (
      .cpu_clk     (cpu_clk),
      .cpu_rst_l   (cpu_rst_l),
      .pop_state   (pop_state),
      .driving_bsc (driving_bsc),
      .rhq_rdata   (rhq_rdata),
      .data_cnt    (data_cnt)
   );

   // Flow control against the slice
   sctag_credit_tracker #(
      .IB_CREDITS (IB_CREDITS)
   ) u_credit_tracker (
      .cpu_clk               (cpu_clk),
      .cpu_rst_l             (cpu_rst_l),
      .max_wris              (max_wris),
      .sctag_jbi_iq_dequeue  (sctag_jbi_iq_dequeue),
      .sctag_jbi_wib_dequeue (sctag_jbi_wib_dequeue),
      .jbi_sctag_req_vld     (jbi_sctag_req_vld),
      .jbi_sctag_req         (jbi_sctag_req),
      .stall_ib              (stall_ib),
      .stall_wib             (stall_wib)
   );

   // Outbound word path
   sctag_req_mux u_req_mux (
      .cpu_clk           (cpu_clk),
      .cpu_rst_l         (cpu_rst_l),
      .pop_state         (pop_state),
      .driving_bsc       (driving_bsc),
      .data_cnt          (data_cnt),
      .rhq_rdata         (rhq_rdata),
      .rdq_rdata         (rdq_rdata),
      .biq_rdata_data    (biq_rdata_data),
      .biq_rdata_ecc     (biq_rdata_ecc),
      .jbi_sctag_req_vld (jbi_sctag_req_vld),
      .jbi_sctag_req     (jbi_sctag_req),
      .jbi_scbuf_ecc     (jbi_scbuf_ecc)
   );

endmodule

/* rq_issue_assertions.sv */
`timescale 1ns/1ps

// Request issue protocol checks
// Concurrent properties on the slice request and the queue pops

module rq_issue_assertions (
   input  logic                       cpu_clk,
   input  logic                       cpu_rst_l,
   input  logic                       jbi_sctag_req_vld,
   input  logic                       issue_rhq_pop,
   input  logic                       issue_biq_pop,
   input  logic [rq_pkg::RHQ_W-1:0]   rhq_rdata,
   input  rq_pkg::pop_state_e         pop_state,
   input  logic                       driving_bsc,
   input  sctag_pkg::req_e            winner_op
);

   // Opcode inside the full 64-bit header
   localparam int OP_HI = sctag_pkg::REQ_HI + sctag_pkg::WORD_W;
   localparam int OP_LO = sctag_pkg::REQ_LO + sctag_pkg::WORD_W;

   // One vld per transaction, never back to back
   vld_single_cycle: assert property (@(posedge cpu_clk) disable iff (!cpu_rst_l)
      jbi_sctag_req_vld |=> !jbi_sctag_req_vld)
      else $error("vld high in two cycles in a row");

   // Only one header source per cycle
   pops_exclusive: assert property (@(posedge cpu_clk) disable iff (!cpu_rst_l)
      !(issue_rhq_pop && issue_biq_pop))
      else $error("RHQ and BIQ header pops together");

   // Full line write from the RHQ is line aligned
   rhq_wri_aligned: assert property (@(posedge cpu_clk) disable iff (!cpu_rst_l)
      (issue_rhq_pop && (rhq_rdata[OP_HI:OP_LO] == sctag_pkg::REQ_WRI))
      |-> (rhq_rdata[5:0] == 6'h0))
      else $error("RHQ WRI with nonzero address bits 5:0");

   // BIQ carries no partial writes
   biq_no_wr8: assert property (@(posedge cpu_clk) disable iff (!cpu_rst_l)
      ((pop_state == rq_pkg::HDR1) && driving_bsc) |-> (winner_op != sctag_pkg::REQ_WR8))
      else $error("WR8 issued from the BIQ");

endmodule

bind rq_issue_top rq_issue_assertions u_assertions (
   .cpu_clk           (cpu_clk),
   .cpu_rst_l         (cpu_rst_l),
   .jbi_sctag_req_vld (jbi_sctag_req_vld),
   .issue_rhq_pop     (issue_rhq_pop),
   .issue_biq_pop     (issue_biq_pop),
   .rhq_rdata         (rhq_rdata),
   .pop_state         (pop_state),
   .driving_bsc       (driving_bsc),
   .winner_op         (winner_op)
);

/* tb_rq_issue.sv */
`timescale 1ns/1ps

// Request issue stage testbench
// Queue models, an L2 slice credit model, a reference beat function
// and a comparing process on the slice request bus

module tb_rq_issue;

   localparam int IB_CREDITS = sctag_pkg::IB_CREDITS_DEF;

   logic          cpu_clk = 1'b0;
   logic          cpu_rst_l;
   logic [1:0]    max_wris;
   logic          rhq_drdy = 1'b0;
   logic [63:0]   rhq_rdata = '0;
   logic [155:0]  rdq_rdata = '0;
   logic          biq_drdy = 1'b0;
   logic [63:0]   biq_rdata_data = '0;
   logic [13:0]   biq_rdata_ecc = '0;
   logic          sctag_jbi_iq_dequeue = 1'b0;
   logic          sctag_jbi_wib_dequeue = 1'b0;
   logic          issue_rhq_pop;
   logic          issue_rdq_pop;
   logic          issue_biq_pop;
   logic          jbi_sctag_req_vld;
   logic [31:0]   jbi_sctag_req;
   logic [6:0]    jbi_scbuf_ecc;

   // Queue contents seen by the DUT, and what the slice should get
   logic [63:0]   rhq_q[$];
   logic [155:0]  rdq_q[$];
   logic [63:0]   biq_d_q[$];
   logic [13:0]   biq_e_q[$];
   logic [63:0]   exp_rhq_hdr[$];
   logic [155:0]  exp_rhq_dat[$];
   logic [63:0]   exp_biq_hdr[$];
   logic [77:0]   exp_biq_dat[$];

   logic [31:0]   lfsr = 32'hf809_89e7;
   logic          cur_src;
   logic [63:0]   cur_hdr;
   logic [623:0]  cur_pay;
   int            beat = 0;
   int            n_beats = 0;
   int            iq_out = 0;
   int            wib_out = 0;
   int            iq_wait = 0;
   int            wib_wait = 0;
   int            dly_bits = 1;
   logic          alt_on = 1'b0;
   int            alt_idx = 0;
   int            n_rhq_pop = 0;
   int            n_rdq_pop = 0;
   int            n_biq_pop = 0;
   int            exp_n_rhq = 0;
   int            exp_n_rdq = 0;
   int            exp_n_biq = 0;
   int            n_mismatch = 0;
   int            n_proto = 0;
   int            n_timeout = 0;

   rq_issue_top #(.IB_CREDITS(IB_CREDITS)) dut (.*);

   always #5 cpu_clk = ~cpu_clk;

   // Galois LFSR, one step per bit taken
   function automatic logic [63:0] lfsr_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[62:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return r;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got %0h expected %0h at %0t", name, got, exp, $time);
         n_mismatch++;
      end
   endtask

   task automatic report_error(input string msg);
      $display("ERROR: %s at %0t", msg, $time);
      n_proto++;
   endtask

   // Queue entries behind one header
   function automatic int entry_count(input logic src, input logic [2:0] op);
      if (op == sctag_pkg::REQ_WRI) return src ? 8 : 4;
      if (op == sctag_pkg::REQ_WR8) return 1;
      return 0;
   endfunction

   // ************************************************
   // Reference beat: {ecc, word} for beat n of a transaction
   // ************************************************
   function automatic logic [38:0] ref_beat(input logic src, input logic [63:0] hdr,
                                            input logic [623:0] pay, input int n);
      int           d;
      int           w;
      logic [155:0] ent;
      logic [77:0]  bent;
      d = n - 2;
      if (n == 0) return {7'h0, hdr[63:32]};
      if (n == 1) return {7'h0, hdr[31:0]};
      // BIQ entry is {ecc, data}, high half first
      if (src) begin
         bent = pay[(d / 2) * 78 +: 78];
         if (d % 2 == 0) return {bent[77:71], bent[63:32]};
         return {bent[70:64], bent[31:0]};
      end
      // WR8 picks its pair from address bit 3
      if (hdr[60:58] == sctag_pkg::REQ_WR8) begin
         ent = pay[155:0];
         w   = (hdr[3] ? 2 : 0) + d;
      end else begin
         ent = pay[(d / 4) * 156 +: 156];
         w   = d % 4;
      end
      return {ent[128 + (3 - w) * 7 +: 7], ent[(3 - w) * 32 +: 32]};
   endfunction

   task automatic push_txn(input logic src, input logic [2:0] op, input logic a3);
      logic [63:0]  hdr;
      logic [155:0] ent;
      int           n;
      hdr         = lfsr_bits(64);
      hdr[63]     = src;
      hdr[60:58]  = op;
      if (op == sctag_pkg::REQ_WRI && !src) hdr[5:0] = 6'h0;
      if (op == sctag_pkg::REQ_WR8) hdr[3] = a3;
      n = entry_count(src, op);
      if (src) begin
         biq_d_q.push_back(hdr);
         biq_e_q.push_back(14'(lfsr_bits(14)));
         exp_biq_hdr.push_back(hdr);
         for (int i = 0; i < n; i++) begin
            ent[77:0] = {14'(lfsr_bits(14)), lfsr_bits(64)};
            biq_d_q.push_back(ent[63:0]);
            biq_e_q.push_back(ent[77:64]);
            exp_biq_dat.push_back(ent[77:0]);
         end
         exp_n_biq += 1 + n;
      end else begin
         rhq_q.push_back(hdr);
         exp_rhq_hdr.push_back(hdr);
         for (int i = 0; i < n; i++) begin
            for (int k = 0; k < 4; k++) ent[k * 32 +: 32] = 32'(lfsr_bits(32));
            ent[155:128] = 28'(lfsr_bits(28));
            rdq_q.push_back(ent);
            exp_rhq_dat.push_back(ent);
         end
         exp_n_rhq++;
         exp_n_rdq += n;
      end
   endtask

   // ************************************************
   // Queue models, heads valid at once, pop at the edge
   // ************************************************
   always @(posedge cpu_clk) begin
      if (cpu_rst_l) begin
         if (issue_rhq_pop && issue_biq_pop) report_error("RHQ and BIQ popped together");
         if (issue_rhq_pop) begin
            n_rhq_pop++;
            if (rhq_q.size() == 0) report_error("RHQ popped while empty");
            else rhq_q.delete(0);
         end
         if (issue_rdq_pop) begin
            n_rdq_pop++;
            if (rdq_q.size() == 0) report_error("RDQ popped while empty");
            else rdq_q.delete(0);
         end
         if (issue_biq_pop) begin
            n_biq_pop++;
            if (biq_d_q.size() == 0) begin
               report_error("BIQ popped while empty");
            end else begin
               biq_d_q.delete(0);
               biq_e_q.delete(0);
            end
         end
      end
      rhq_drdy       <= (rhq_q.size() != 0);
      rhq_rdata      <= (rhq_q.size() != 0) ? rhq_q[0] : '0;
      rdq_rdata      <= (rdq_q.size() != 0) ? rdq_q[0] : '0;
      biq_drdy       <= (biq_d_q.size() != 0);
      biq_rdata_data <= (biq_d_q.size() != 0) ? biq_d_q[0] : '0;
      biq_rdata_ecc  <= (biq_e_q.size() != 0) ? biq_e_q[0] : '0;
   end

   // Slice model, returns credits after random delays
   always @(posedge cpu_clk) begin
      sctag_jbi_iq_dequeue  <= 1'b0;
      sctag_jbi_wib_dequeue <= 1'b0;
      if (cpu_rst_l) begin
         if (jbi_sctag_req_vld) begin
            iq_out++;
            if (iq_out > IB_CREDITS) report_error("more requests outstanding than IB credits");
            if (jbi_sctag_req[sctag_pkg::REQ_HI:sctag_pkg::REQ_LO] == sctag_pkg::REQ_WRI) begin
               wib_out++;
               if (wib_out > max_wris + 1) report_error("more WRIs outstanding than WIB limit");
            end
         end
         if (iq_wait != 0) begin
            iq_wait--;
         end else if (iq_out != 0) begin
            sctag_jbi_iq_dequeue <= 1'b1;
            iq_out--;
            iq_wait = int'(lfsr_bits(dly_bits));
         end
         if (wib_wait != 0) begin
            wib_wait--;
         end else if (wib_out != 0) begin
            sctag_jbi_wib_dequeue <= 1'b1;
            wib_out--;
            wib_wait = int'(lfsr_bits(dly_bits));
         end
      end
   end

   // Next expected transaction of the source tagged in header bit 63
   task automatic start_txn(input logic src);
      int n;
      cur_src = src;
      cur_pay = '0;
      beat    = 0;
      n_beats = 0;
      if ((src && exp_biq_hdr.size() == 0) || (!src && exp_rhq_hdr.size() == 0)) begin
         report_error("vld with no transaction queued for its source");
         return;
      end
      cur_hdr = src ? exp_biq_hdr.pop_front() : exp_rhq_hdr.pop_front();
      n       = entry_count(src, cur_hdr[60:58]);
      for (int i = 0; i < n; i++) begin
         if (src) cur_pay[i * 78 +: 78] = exp_biq_dat.pop_front();
         else cur_pay[i * 156 +: 156] = exp_rhq_dat.pop_front();
      end
      n_beats = 2 + ((cur_hdr[60:58] == sctag_pkg::REQ_WRI) ? 16 :
                     (cur_hdr[60:58] == sctag_pkg::REQ_WR8) ? 2 : 0);
   endtask

   // ************************************************
   // Comparing process
   // ************************************************
   always @(posedge cpu_clk) begin
      logic [38:0] exp_b;
      if (cpu_rst_l) begin
         if (jbi_sctag_req_vld) begin
            if (beat < n_beats) report_error("vld in the middle of a transaction");
            if (alt_on) begin
               check_value("jbi_sctag_req[31]", jbi_sctag_req[31], alt_idx % 2);
               alt_idx++;
            end
            start_txn(jbi_sctag_req[31]);
         end
         if (beat < n_beats) begin
            exp_b = ref_beat(cur_src, cur_hdr, cur_pay, beat);
            check_value("jbi_sctag_req", jbi_sctag_req, exp_b[31:0]);
            // Header ECC is left unchecked
            if (beat >= 2) check_value("jbi_scbuf_ecc", jbi_scbuf_ecc, exp_b[38:32]);
            beat++;
         end
      end
   end

   function automatic logic drained();
      return rhq_q.size() == 0 && rdq_q.size() == 0 && biq_d_q.size() == 0
          && exp_rhq_hdr.size() == 0 && exp_biq_hdr.size() == 0
          && beat >= n_beats && iq_out == 0 && wib_out == 0;
   endfunction

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while (!drained() && n < limit) begin
         @(posedge cpu_clk);
         n++;
      end
      if (!drained()) begin
         $display("ERROR: transactions still pending after %0d cycles", limit);
         n_timeout++;
      end
   endtask

   initial begin
      cpu_rst_l <= 1'b0;
      max_wris  <= 2'd3;
      repeat (5) @(posedge cpu_clk);
      cpu_rst_l <= 1'b1;

      // Empty queues, nothing moves
      for (int i = 0; i < 20; i++) begin
         @(negedge cpu_clk);
         check_value("jbi_sctag_req_vld", jbi_sctag_req_vld, 0);
         check_value("issue_rhq_pop", issue_rhq_pop, 0);
         check_value("issue_rdq_pop", issue_rdq_pop, 0);
         check_value("issue_biq_pop", issue_biq_pop, 0);
      end

      // Both sources loaded together, RHQ first then alternate
      alt_on = 1'b1;
      for (int i = 0; i < 4; i++) begin
         push_txn(1'b0, sctag_pkg::REQ_RDD, 1'b0);
         push_txn(1'b1, sctag_pkg::REQ_RDD, 1'b0);
      end
      wait_drain(2000);
      alt_on = 1'b0;
      check_value("alternating vld count", alt_idx, 8);

      // Directed opcodes from each source
      @(negedge cpu_clk);
      push_txn(1'b0, sctag_pkg::REQ_WRI, 1'b0);
      push_txn(1'b0, sctag_pkg::REQ_WR8, 1'b0);
      push_txn(1'b0, sctag_pkg::REQ_WR8, 1'b1);
      push_txn(1'b0, sctag_pkg::REQ_RDD, 1'b0);
      push_txn(1'b1, sctag_pkg::REQ_WRI, 1'b0);
      push_txn(1'b1, sctag_pkg::REQ_RDD, 1'b0);
      wait_drain(2000);

      // Random mix, slow returns, every WIB limit
      dly_bits = 5;
      for (int w = 0; w < 4; w++) begin
         @(posedge cpu_clk);
         max_wris <= 2'(w);
         @(negedge cpu_clk);
         for (int i = 0; i < 6; i++) begin
            case (2'(lfsr_bits(2)))
               2'd0:    push_txn(1'b0, sctag_pkg::REQ_RDD, 1'b0);
               2'd1:    push_txn(1'b0, sctag_pkg::REQ_WR8, lfsr_bits(1) != 0);
               default: push_txn(1'b0, sctag_pkg::REQ_WRI, 1'b0);
            endcase
            push_txn(1'b1, lfsr_bits(1) != 0 ? sctag_pkg::REQ_WRI : sctag_pkg::REQ_RDD, 1'b0);
         end
         wait_drain(20000);
      end

      check_value("issue_rhq_pop count", n_rhq_pop, exp_n_rhq);
      check_value("issue_rdq_pop count", n_rdq_pop, exp_n_rdq);
      check_value("issue_biq_pop count", n_biq_pop, exp_n_biq);

      $display("Done: %0d mismatches, %0d protocol errors, %0d timeouts",
               n_mismatch, n_proto, n_timeout);
      if (n_mismatch + n_proto + n_timeout == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* tb.f */
rq_pkg.sv
sctag_pkg.sv
rq_issue_arbiter.sv
rq_pop_fsm.sv
rq_data_counter.sv
sctag_credit_tracker.sv
sctag_req_mux.sv
rq_issue_top.sv
rq_issue_assertions.sv
tb_rq_issue.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the request issue testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal --top-module tb_rq_issue -f tb.f
./obj_dir/Vtb_rq_issue | tee sim.log

if grep -q "All checks passed" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi
